/* cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// general registers
`define CPU_NREG 8

// memory depths in 16-bit words
`define CPU_IMEM_DEPTH 256
`define CPU_DMEM_DEPTH 256

// data access latency, 1 to 4 cycles
`define CPU_MEM_CYCLES 2

`endif

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	// major opcode, bits [15:11] of every word
	typedef enum logic [4:0] {
		NOP   = 5'h00,
		RTYPE = 5'h01,
		ADDIU = 5'h02,
		LI    = 5'h03,
		LW    = 5'h04,
		SW    = 5'h05,
		BEQZ  = 5'h06
	} opcode_e;

	// funct field of an R-type word, also the ALU select
	typedef enum logic [1:0] {
		ALU_ADDU = 2'b00,
		ALU_SUBU = 2'b01,
		ALU_AND  = 2'b10,
		ALU_OR   = 2'b11
	} alu_fn_e;

	typedef struct packed {
		opcode_e    op;
		logic [2:0] rx;
		logic [2:0] ry;
		logic [2:0] rz;
		alu_fn_e    funct;
	} inst_r_t;

	typedef struct packed {
		opcode_e    op;
		logic [2:0] rx;
		logic [7:0] imm;
	} inst_i_t;

	// same 16 bits, two decodings
	typedef union packed {
		inst_r_t r;
		inst_i_t i;
	} inst_u;

	typedef struct packed {
		alu_fn_e     alu_fn;
		logic        use_imm;
		logic [15:0] imm16;
		logic        reg_write;
		logic [2:0]  dest;
		logic        mem_read;
		logic        mem_write;
		logic [2:0]  src_a;
		logic        use_a;
		logic [2:0]  src_b;
		logic        use_b;
	} id_ctrl_t;

	typedef struct packed {
		logic        reg_write;
		logic [2:0]  dest;
		logic [15:0] value;
	} wb_t;

endpackage

`default_nettype wire

/* pc_fetch.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module pc_fetch (
	input  logic           clk,
	input  logic           rst,
	input  logic           run,
	input  logic           hold,
	input  logic           set_pc,
	input  logic [15:0]    set_pc_addr,
	input  logic           boot_we,
	input  logic [7:0]     boot_addr,
	input  logic [15:0]    boot_data,
	output cpu_pkg::inst_u id_inst,
	output logic [15:0]    id_pc
);

	localparam int IW = $clog2(`CPU_IMEM_DEPTH);

	logic [15:0] imem [`CPU_IMEM_DEPTH];
	logic [15:0] pc;

	// boot port, usable whether or not the core runs
	always_ff @(posedge clk) begin
		if (boot_we) begin
			imem[boot_addr] <= boot_data;
		end
	end

	// branch target wins over the increment
	always_ff @(posedge clk) begin
		if (rst || !run) begin
			pc <= '0;
		end else if (!hold) begin
			if (set_pc) begin
				pc <= set_pc_addr;
			end else begin
				pc <= pc + 16'd1;
			end
		end
	end

	// IF/ID, doubles as the synchronous read port of imem
	always_ff @(posedge clk) begin
		if (rst || !run) begin
			id_inst <= '0;
			id_pc <= '0;
		end else if (!hold) begin
			id_inst <= imem[pc[IW-1:0]];
			id_pc <= pc;
		end
	end

endmodule

`default_nettype wire

/* decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module decoder (
	input  cpu_pkg::inst_u    id_inst,
	input  logic [15:0]       id_pc,
	input  logic [15:0]       rdata_a,
	output logic [2:0]        raddr_a,
	output logic [2:0]        raddr_b,
	output cpu_pkg::id_ctrl_t ctrl,
	output logic              set_pc,
	output logic [15:0]       set_pc_addr
);
	import cpu_pkg::*;

	logic [15:0] imm_sext;
	logic [15:0] imm_zext;

	assign imm_sext = {{8{id_inst.i.imm[7]}}, id_inst.i.imm};
	assign imm_zext = {8'h00, id_inst.i.imm};

	// rx and ry sit at the same bits in every format
	assign raddr_a = id_inst.r.rx;
	assign raddr_b = id_inst.r.ry;

	// relative to the delay slot
	assign set_pc_addr = id_pc + 16'd1 + imm_sext;

	always_comb begin
		ctrl = '0;
		ctrl.src_a = id_inst.r.rx;
		ctrl.src_b = id_inst.r.ry;
		set_pc = 1'b0;
		case (id_inst.r.op)
			RTYPE: begin
				ctrl.alu_fn = id_inst.r.funct;
				ctrl.reg_write = 1'b1;
				ctrl.dest = id_inst.r.rz;
				ctrl.use_a = 1'b1;
				ctrl.use_b = 1'b1;
			end
			ADDIU: begin
				ctrl.use_imm = 1'b1;
				ctrl.imm16 = imm_sext;
				ctrl.reg_write = 1'b1;
				ctrl.dest = id_inst.i.rx;
				ctrl.use_a = 1'b1;
			end
			LI: begin
				// operand a stays zero, so rx = 0 + imm
				ctrl.use_imm = 1'b1;
				ctrl.imm16 = imm_zext;
				ctrl.reg_write = 1'b1;
				ctrl.dest = id_inst.i.rx;
			end
			LW: begin
				ctrl.mem_read = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.dest = id_inst.r.rz;
				ctrl.use_a = 1'b1;
				ctrl.use_b = 1'b1;
			end
			SW: begin
				// address rx + 0, ry is the store data
				ctrl.mem_write = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.use_a = 1'b1;
				ctrl.use_b = 1'b1;
			end
			BEQZ: begin
				ctrl.use_a = 1'b1;
				set_pc = (rdata_a == 16'h0000);
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module reg_file (
	input  logic         clk,
	input  logic         rst,
	input  logic [2:0]   raddr_a,
	input  logic [2:0]   raddr_b,
	output logic [15:0]  rdata_a,
	output logic [15:0]  rdata_b,
	input  cpu_pkg::wb_t wb
);

	logic [15:0] regs [`CPU_NREG];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.reg_write) begin
			regs[wb.dest] <= wb.value;
		end
	end

	// write-through, ID sees the value written this cycle
	assign rdata_a = (wb.reg_write && wb.dest == raddr_a) ? wb.value : regs[raddr_a];
	assign rdata_b = (wb.reg_write && wb.dest == raddr_b) ? wb.value : regs[raddr_b];

endmodule

`default_nettype wire

/* hazard_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
	input  logic              clk,
	input  logic              rst,
	input  cpu_pkg::id_ctrl_t id_ctrl,
	input  logic [2:0]        exe_dest,
	input  logic              exe_reg_write,
	input  logic              mem_start,
	input  logic              mem_done,
	output logic              hold,
	output logic              bubble
);

	logic mem_busy;
	logic hold_mem;
	logic hold_raw;
	logic hit_a;
	logic hit_b;

	// access in flight between start and done
	always_ff @(posedge clk) begin
		if (rst) begin
			mem_busy <= 1'b0;
		end else if (mem_start) begin
			mem_busy <= 1'b1;
		end else if (mem_done) begin
			mem_busy <= 1'b0;
		end
	end

	assign hold_mem = mem_start | (mem_busy & ~mem_done);

	// WB needs no check, reg_file writes through
	assign hit_a = id_ctrl.use_a && (id_ctrl.src_a == exe_dest);
	assign hit_b = id_ctrl.use_b && (id_ctrl.src_b == exe_dest);
	assign hold_raw = exe_reg_write && (hit_a || hit_b);

	assign hold = hold_raw | hold_mem;
	// EXE drains only when memory is not holding it
	assign bubble = hold_raw & ~hold_mem;

endmodule

`default_nettype wire

/* execute_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
	input  logic              clk,
	input  logic              rst,
	input  logic              hold,
	input  logic              bubble,
	input  cpu_pkg::id_ctrl_t ctrl,
	input  logic [15:0]       rdata_a,
	input  logic [15:0]       rdata_b,
	input  logic              mem_done,
	input  logic [15:0]       mem_rdata,
	output logic              mem_start,
	output logic              mem_we,
	output logic [7:0]        mem_addr,
	output logic [15:0]       mem_wdata,
	output logic [2:0]        exe_dest,
	output logic              exe_reg_write,
	output cpu_pkg::wb_t      wb
);
	import cpu_pkg::*;

	id_ctrl_t    exe;
	logic        exe_new;
	logic [15:0] opa;
	logic [15:0] opb;
	logic [15:0] alu_a;
	logic [15:0] alu_b;
	logic [15:0] alu_y;
	wb_t         wb_d;

	// ID/EXE control, exe_new marks the first cycle of an instruction
	always_ff @(posedge clk) begin
		if (rst) begin
			exe <= '0;
			exe_new <= 1'b0;
		end else if (bubble) begin
			exe <= '0;
			exe_new <= 1'b1;
		end else if (!hold) begin
			exe <= ctrl;
			exe_new <= 1'b1;
		end else begin
			exe_new <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			opa <= rdata_a;
			opb <= rdata_b;
		end
	end

	assign alu_a = exe.use_a ? opa : 16'h0000;
	assign alu_b = exe.use_imm ? exe.imm16 : opb;

	always_comb begin
		case (exe.alu_fn)
			ALU_ADDU: alu_y = alu_a + alu_b;
			ALU_SUBU: alu_y = alu_a - alu_b;
			ALU_AND:  alu_y = alu_a & alu_b;
			// ALU_OR
			default:  alu_y = alu_a | alu_b;
		endcase
	end

	// one strobe per access
	assign mem_start = (exe.mem_read | exe.mem_write) & exe_new;
	assign mem_we = exe.mem_write;
	assign mem_addr = alu_y[7:0];
	assign mem_wdata = opb;

	assign exe_dest = exe.dest;
	assign exe_reg_write = exe.reg_write;

	// a load writes back only once its data is back
	always_comb begin
		wb_d.reg_write = exe.reg_write & (~exe.mem_read | mem_done);
		wb_d.dest = exe.dest;
		wb_d.value = exe.mem_read ? mem_rdata : alu_y;
	end

	// EXE/WB
	always_ff @(posedge clk) begin
		if (rst) begin
			wb <= '0;
		end else begin
			wb <= wb_d;
		end
	end

endmodule

`default_nettype wire

/* data_mem_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module data_mem_ctrl (
	input  logic        clk,
	input  logic        rst,
	input  logic        mem_start,
	input  logic        mem_we,
	input  logic [7:0]  mem_addr,
	input  logic [15:0] mem_wdata,
	output logic        mem_done,
	output logic [15:0] mem_rdata
);

	localparam int CW = $clog2(`CPU_MEM_CYCLES + 1);

	logic [15:0]   dram [`CPU_DMEM_DEPTH];
	logic [CW-1:0] cnt;

	// array access happens on the start strobe
	always_ff @(posedge clk) begin
		if (mem_start) begin
			if (mem_we) begin
				dram[mem_addr] <= mem_wdata;
			end
			mem_rdata <= dram[mem_addr];
		end
	end

	// counts down the remaining cycles of the access
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (mem_start) begin
			cnt <= CW'(`CPU_MEM_CYCLES);
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	assign mem_done = (cnt == CW'(1));

endmodule

`default_nettype wire

/* cpu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_top (
	input  logic        clk,
	input  logic        rst,
	input  logic        run,
	input  logic        boot_we,
	input  logic [7:0]  boot_addr,
	input  logic [15:0] boot_data,
	output logic        wb_valid,
	output logic [2:0]  wb_dest,
	output logic [15:0] wb_value
);
	import cpu_pkg::*;

	inst_u       id_inst;
	logic [15:0] id_pc;
	logic        set_pc;
	logic [15:0] set_pc_addr;
	logic [2:0]  raddr_a;
	logic [2:0]  raddr_b;
	logic [15:0] rdata_a;
	logic [15:0] rdata_b;
	id_ctrl_t    id_ctrl;
	logic        hold;
	logic        bubble;
	logic [2:0]  exe_dest;
	logic        exe_reg_write;
	logic        mem_start;
	logic        mem_we;
	logic        mem_done;
	logic [7:0]  mem_addr;
	logic [15:0] mem_wdata;
	logic [15:0] mem_rdata;
	wb_t         wb;

	pc_fetch i_pc_fetch (
		.clk(clk), .rst(rst), .run(run), .hold(hold),
		.set_pc(set_pc), .set_pc_addr(set_pc_addr),
		.boot_we(boot_we), .boot_addr(boot_addr), .boot_data(boot_data),
		.id_inst(id_inst), .id_pc(id_pc)
	);

	decoder i_decoder (
		.id_inst(id_inst), .id_pc(id_pc), .rdata_a(rdata_a),
		.raddr_a(raddr_a), .raddr_b(raddr_b), .ctrl(id_ctrl),
		.set_pc(set_pc), .set_pc_addr(set_pc_addr)
	);

	reg_file i_reg_file (
		.clk(clk), .rst(rst), .raddr_a(raddr_a), .raddr_b(raddr_b),
		.rdata_a(rdata_a), .rdata_b(rdata_b), .wb(wb)
	);

	hazard_unit i_hazard_unit (
		.clk(clk), .rst(rst), .id_ctrl(id_ctrl),
		.exe_dest(exe_dest), .exe_reg_write(exe_reg_write),
		.mem_start(mem_start), .mem_done(mem_done),
		.hold(hold), .bubble(bubble)
	);

	execute_stage i_execute_stage (
		.clk(clk), .rst(rst), .hold(hold), .bubble(bubble), .ctrl(id_ctrl),
		.rdata_a(rdata_a), .rdata_b(rdata_b),
		.mem_done(mem_done), .mem_rdata(mem_rdata),
		.mem_start(mem_start), .mem_we(mem_we),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.exe_dest(exe_dest), .exe_reg_write(exe_reg_write), .wb(wb)
	);

	data_mem_ctrl i_data_mem_ctrl (
		.clk(clk), .rst(rst), .mem_start(mem_start), .mem_we(mem_we),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_done(mem_done), .mem_rdata(mem_rdata)
	);

	// observation port, one strobe per register write
	assign wb_valid = wb.reg_write;
	assign wb_dest = wb.dest;
	assign wb_value = wb.value;

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst
);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset held over the first five rising edges
	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

/* tb_cpu.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module tb_cpu;

	localparam int TIMEOUT = 2000;
	localparam int CASES_DEPTH = 512;

	logic        clk;
	logic        rst;
	logic        run;
	logic        boot_we;
	logic [7:0]  boot_addr;
	logic [15:0] boot_data;
	logic        wb_valid;
	logic [2:0]  wb_dest;
	logic [15:0] wb_value;

	// two counts, the program words, then dest/value pairs
	logic [15:0] cases [CASES_DEPTH];
	int          nprog;
	int          nexp;
	int          exp_base;
	logic [2:0]  exp_dest;
	logic [15:0] exp_value;

	tb_clock i_tb_clock (
		.clk(clk),
		.rst(rst)
	);

	cpu_top i_cpu_top (
		.clk(clk), .rst(rst), .run(run),
		.boot_we(boot_we), .boot_addr(boot_addr), .boot_data(boot_data),
		.wb_valid(wb_valid), .wb_dest(wb_dest), .wb_value(wb_value)
	);

	task automatic stop_failed;
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		$display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
		stop_failed();
	endtask

	task automatic report_error(input string what);
		$display("ERROR at %0t: %s", $time, what);
		stop_failed();
	endtask

	task automatic wait_reset_release;
		int cycles;
		cycles = 0;
		while (rst !== 1'b0 && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		assert (rst === 1'b0) else report_error("reset was never released");
	endtask

	// program goes in while run is low, then the core starts at pc 0
	task automatic boot_program;
		for (int i = 0; i < nprog; i++) begin
			@(posedge clk);
			boot_we <= 1'b1;
			boot_addr <= 8'(i);
			boot_data <= cases[2 + i];
		end
		@(posedge clk);
		boot_we <= 1'b0;
		run <= 1'b1;
	endtask

	// sampled on the falling edge, away from the register updates
	task automatic wait_for_writeback(input int idx);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (wb_valid !== 1'b1 && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		assert (wb_valid === 1'b1)
			else report_error($sformatf("write-back %0d did not come within %0d cycles",
				idx, TIMEOUT));
	endtask

	// the program ends in a spin loop, so nothing more may be written
	task automatic check_quiet_tail;
		for (int c = 0; c < TIMEOUT; c++) begin
			@(negedge clk);
			assert (wb_valid === 1'b0)
				else report_error($sformatf("extra write-back to r%0d with value %h",
					wb_dest, wb_value));
		end
	endtask

	initial begin
		run = 1'b0;
		boot_we = 1'b0;
		boot_addr = '0;
		boot_data = '0;
		$readmemh("cpu_cases.txt", cases);
		assert (!$isunknown(cases[0]) && !$isunknown(cases[1]))
			else report_error("cpu_cases.txt is missing or has no count line");
		nprog = int'(cases[0]);
		nexp = int'(cases[1]);
		exp_base = 2 + nprog;
		assert (nprog > 0 && nprog <= `CPU_IMEM_DEPTH && nexp > 0
				&& exp_base + 2 * nexp <= CASES_DEPTH)
			else report_error("the counts in cpu_cases.txt do not fit the tables");
		wait_reset_release();
		boot_program();
		for (int k = 0; k < nexp; k++) begin
			exp_dest = cases[exp_base + 2 * k][2:0];
			exp_value = cases[exp_base + 2 * k + 1];
			wait_for_writeback(k);
			assert (wb_dest == exp_dest)
				else report_mismatch("wb_dest", {13'd0, wb_dest}, {13'd0, exp_dest});
			assert (wb_value == exp_value)
				else report_mismatch("wb_value", wb_value, exp_value);
		end
		check_quiet_tail();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* cpu_cases.txt */
// first line: number of program words, number of expected write-backs
// then the program words from address 0, then one dest/value pair per line
001a 0015
// 0..4 LI zero-extends, ADDIU sign-extends (fe, 80 are negative)
1905 1aff 12fe 1180 117f
// 5..8 ADDU SUBU AND OR, each reading the result before it
094c 0b31 0c76 0d3b
// 9..11 SW r3 to mem[r1], LW r5 from mem[r1 + r7], ADDU r6 = r5 + r5
2960 21f4 0db8
// 12..16 BEQZ r4 taken to 17, delay slot at 14, 15 and 16 skipped
1c00 3403 1b33 1b44 1a55
// 17..22 countdown loop on r1, r2 bumped in the delay slot
1903 11ff 3103 1201 37fc 0000
// 23..25 exit marker, then spin on r7 which stays zero
1e77 37ff 0000
// expected write-backs, dest then value
0001 0005
0002 00ff
0002 00fd
0001 ff85
0001 0004
0003 0101
0004 00fd
0005 0001
0006 0005
0005 0101
0006 0202
0004 0000
0003 0033
0001 0003
0001 0002
0002 00fe
0001 0001
0002 00ff
0001 0000
0002 0100
0006 0077

/* flist.f */
+incdir+.
cpu_pkg.sv
pc_fetch.sv
decoder.sv
reg_file.sv
hazard_unit.sv
execute_stage.sv
data_mem_ctrl.sv
cpu_top.sv
tb_clock.sv
tb_cpu.sv

/* Bender.yml */
package:
  name: cpu16_pipeline

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - pc_fetch.sv
      - decoder.sv
      - reg_file.sv
      - hazard_unit.sv
      - execute_stage.sv
      - data_mem_ctrl.sv
      - cpu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock.sv
      - tb_cpu.sv
